// ==== br_stack.sv ====
`timescale 1ns/1ps

module br_stack #(
    parameter int ARCH_REGS = 32,
    parameter int PHYS_REGS = 64,
    parameter int DEPTH     = 4
) (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          checkpoint_en,
    input  logic [ARCH_REGS*($clog2(PHYS_REGS)+1)-1:0]    map_flat,
    input  logic [$clog2(PHYS_REGS-ARCH_REGS):0]          fl_head,
    input  logic                                          broadcast_en,
    input  logic [$clog2(PHYS_REGS)-1:0]                  broadcast_preg,
    input  rename_pkg::br_task_t                          br_task,
    input  logic [DEPTH-1:0]                              rem_b_id,
    output logic                                          restore_en,
    output logic [ARCH_REGS*($clog2(PHYS_REGS)+1)-1:0]    restore_map,
    output logic [$clog2(PHYS_REGS-ARCH_REGS):0]          restore_head,
    output logic                                          full,
    output logic [DEPTH-1:0]                              new_b_id
);

    localparam int PW   = $clog2(PHYS_REGS);
    localparam int EW   = PW + 1;
    localparam int MW   = ARCH_REGS * EW;
    localparam int PTRW = $clog2(PHYS_REGS - ARCH_REGS) + 1;

    typedef logic [DEPTH-1:0] bmask_t;
    typedef logic [MW-1:0]    map_t;
    typedef logic [PTRW-1:0]  ptr_t;

    // the id of a slot is its own one-hot bit, so only valid and mask are tracked
    bmask_t valid;
    bmask_t mask    [DEPTH];
    map_t   cp_map  [DEPTH];
    ptr_t   cp_head [DEPTH];

    // lowest clear bit of valid picks the next slot
    assign new_b_id = ~valid & (valid + 1'b1);
    assign full     = &valid;

    assign restore_en = (br_task == rename_pkg::BR_SQUASH) && |(valid & rem_b_id);

    always_comb begin
        restore_map  = '0;
        restore_head = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (rem_b_id[i]) begin
                restore_map  = cp_map[i];
                restore_head = cp_head[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                mask[i] <= '0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                case (br_task)
                    // squash kills the branch and everything younger
                    rename_pkg::BR_SQUASH: begin
                        if (|(mask[i] & rem_b_id)) begin
                            valid[i] <= 1'b0;
                        end
                    end
                    rename_pkg::BR_CLEAR: begin
                        if (rem_b_id[i]) begin
                            valid[i] <= 1'b0;
                        end
                        mask[i] <= mask[i] & ~rem_b_id;
                    end
                    default: ;
                endcase
            end
            if (checkpoint_en) begin
                for (int i = 0; i < DEPTH; i++) begin
                    if (new_b_id[i]) begin
                        valid[i] <= 1'b1;
                        // depends on itself and every branch still open
                        mask[i]  <= new_b_id | valid;
                    end
                end
            end
        end
    end

    // saved map copies keep catching result broadcasts
    always_ff @(posedge clock) begin
        for (int j = 0; j < DEPTH; j++) begin
            if (checkpoint_en && new_b_id[j]) begin
                cp_map[j]  <= map_flat;
                cp_head[j] <= fl_head;
            end else if (broadcast_en) begin
                for (int i = 0; i < ARCH_REGS; i++) begin
                    if (cp_map[j][i*EW +: PW] == broadcast_preg) begin
                        cp_map[j][i*EW + PW] <= 1'b1;
                    end
                end
            end
        end
    end

    a_rem_id_onehot: assert property (
        @(posedge clock) disable iff (reset)
        (br_task != rename_pkg::BR_NONE) |-> $onehot(rem_b_id)
    ) else $error("resolve with a branch id that is not one-hot");

endmodule

// ==== free_list.sv ====
`timescale 1ns/1ps

module free_list #(
    parameter int ARCH_REGS = 32,
    parameter int PHYS_REGS = 64
) (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          alloc_en,
    input  logic                                          release_en,
    input  logic [$clog2(PHYS_REGS)-1:0]                  release_preg,
    input  logic                                          restore_en,
    input  logic [$clog2(PHYS_REGS-ARCH_REGS):0]          restore_head,
    output logic [$clog2(PHYS_REGS)-1:0]                  head_preg,
    output logic [$clog2(PHYS_REGS-ARCH_REGS):0]          head_ptr,
    output logic [$clog2(PHYS_REGS-ARCH_REGS):0]          count,
    output logic                                          empty
);

    localparam int FL   = PHYS_REGS - ARCH_REGS;
    localparam int IW   = $clog2(FL);
    // extra wrap bit tells full from empty
    localparam int PTRW = IW + 1;
    localparam int PW   = $clog2(PHYS_REGS);

    typedef logic [PW-1:0]   preg_t;
    typedef logic [PTRW-1:0] ptr_t;

    preg_t mem [FL];
    ptr_t  head;
    ptr_t  tail;

    assign head_preg = mem[head[IW-1:0]];
    assign head_ptr  = head;
    assign count     = tail - head;
    assign empty     = (count == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            // every register above the architectural ones starts free
            for (int i = 0; i < FL; i++) begin
                mem[i] <= PW'(ARCH_REGS + i);
            end
            head <= '0;
            tail <= PTRW'(FL);
        end else begin
            if (restore_en) begin
                head <= restore_head;
            end else if (alloc_en && !empty) begin
                head <= head + 1'b1;
            end
            if (release_en) begin
                mem[tail[IW-1:0]] <= release_preg;
                tail <= tail + 1'b1;
            end
        end
    end

    a_no_release_when_full: assert property (
        @(posedge clock) disable iff (reset)
        release_en |-> (count != PTRW'(FL))
    ) else $error("release into a full free list");

endmodule

// ==== map_table.sv ====
`timescale 1ns/1ps

module map_table #(
    parameter int ARCH_REGS = 32,
    parameter int PHYS_REGS = 64
) (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          rename_en,
    input  logic [$clog2(ARCH_REGS)-1:0]                  rename_arch,
    input  logic [$clog2(PHYS_REGS)-1:0]                  rename_preg,
    input  logic                                          empty,
    input  logic                                          broadcast_en,
    input  logic [$clog2(PHYS_REGS)-1:0]                  broadcast_preg,
    input  logic                                          restore_en,
    input  logic [ARCH_REGS*($clog2(PHYS_REGS)+1)-1:0]    restore_map,
    input  logic [$clog2(ARCH_REGS)-1:0]                  lookup_arch,
    output logic [ARCH_REGS*($clog2(PHYS_REGS)+1)-1:0]    map_flat,
    output logic [$clog2(PHYS_REGS)-1:0]                  lookup_preg,
    output logic                                          lookup_ready
);

    localparam int PW = $clog2(PHYS_REGS);
    // one packed entry is {ready, preg}
    localparam int EW = PW + 1;

    typedef logic [PW-1:0] preg_t;

    preg_t                preg_q [ARCH_REGS];
    logic [ARCH_REGS-1:0] ready_q;

    always_comb begin
        for (int i = 0; i < ARCH_REGS; i++) begin
            map_flat[i*EW +: EW] = {ready_q[i], preg_q[i]};
        end
    end

    assign lookup_preg  = preg_q[lookup_arch];
    assign lookup_ready = ready_q[lookup_arch];

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity mapping, everything ready
            for (int i = 0; i < ARCH_REGS; i++) begin
                preg_q[i] <= PW'(i);
            end
            ready_q <= '1;
        end else if (restore_en) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                preg_q[i]  <= restore_map[i*EW +: PW];
                ready_q[i] <= restore_map[i*EW + PW];
            end
        end else begin
            if (broadcast_en) begin
                for (int i = 0; i < ARCH_REGS; i++) begin
                    if (preg_q[i] == broadcast_preg) begin
                        ready_q[i] <= 1'b1;
                    end
                end
            end
            // no free register means the rename is dropped
            if (rename_en && !empty) begin
                preg_q[rename_arch]  <= rename_preg;
                ready_q[rename_arch] <= 1'b0;
            end
        end
    end

endmodule

// ==== rename_ctrl.sv ====
`timescale 1ns/1ps

module rename_ctrl #(
    parameter int ARCH_REGS = 32,
    parameter int PHYS_REGS = 64,
    parameter int DEPTH     = 4
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  cyc,
    input  logic                                  stb,
    input  logic                                  we,
    input  rename_pkg::wb_adr_t                   adr,
    input  rename_pkg::wb_dat_t                   dat_w,
    input  logic [$clog2(PHYS_REGS)-1:0]          lookup_preg,
    input  logic                                  lookup_ready,
    input  logic                                  full,
    input  logic                                  empty,
    input  logic [$clog2(PHYS_REGS-ARCH_REGS):0]  count,
    input  logic [DEPTH-1:0]                      new_b_id,
    output logic                                  ack,
    output rename_pkg::wb_dat_t                   dat_r,
    output logic                                  rename_en,
    output logic [$clog2(ARCH_REGS)-1:0]          rename_arch,
    output logic                                  release_en,
    output logic [$clog2(PHYS_REGS)-1:0]          release_preg,
    output logic                                  broadcast_en,
    output logic [$clog2(PHYS_REGS)-1:0]          broadcast_preg,
    output logic                                  checkpoint_en,
    output rename_pkg::br_task_t                  br_task,
    output logic [DEPTH-1:0]                      rem_b_id,
    output logic [$clog2(ARCH_REGS)-1:0]          lookup_arch
);

    localparam int AW = $clog2(ARCH_REGS);
    localparam int PW = $clog2(PHYS_REGS);

    typedef enum logic {
        ST_IDLE,
        ST_ACK
    } state_t;

    state_t              state;
    logic                req;
    logic                wr;
    logic                is_map;
    rename_pkg::wb_adr_t map_off;
    rename_pkg::wb_dat_t status;
    rename_pkg::wb_dat_t rd_data;
    logic [DEPTH-1:0]    last_b_id;

    // a request is only decoded on its first cycle
    assign req = cyc && stb && (state == ST_IDLE);
    assign wr  = req && we;
    assign ack = (state == ST_ACK);

    assign rename_en     = wr && (adr == rename_pkg::ADR_RENAME);
    assign release_en    = wr && (adr == rename_pkg::ADR_RELEASE);
    assign broadcast_en  = wr && (adr == rename_pkg::ADR_BROADCAST);
    assign checkpoint_en = wr && (adr == rename_pkg::ADR_BRANCH) && !full;

    assign br_task = !(wr && (adr == rename_pkg::ADR_RESOLVE)) ? rename_pkg::BR_NONE :
                     dat_w[8] ? rename_pkg::BR_SQUASH : rename_pkg::BR_CLEAR;

    assign rename_arch    = dat_w[AW-1:0];
    assign release_preg   = dat_w[PW-1:0];
    assign broadcast_preg = dat_w[PW-1:0];
    assign rem_b_id       = dat_w[DEPTH-1:0];

    assign map_off     = adr - rename_pkg::ADR_MAP_BASE;
    assign is_map      = (map_off < ARCH_REGS);
    assign lookup_arch = map_off[AW-1:0];

    always_comb begin
        status             = '0;
        status[31]         = full;
        status[30]         = empty;
        status[16 +: DEPTH] = last_b_id;
        status[7:0]        = 8'(count);

        rd_data = '0;
        if (adr == rename_pkg::ADR_STATUS) begin
            rd_data = status;
        end else if (is_map) begin
            rd_data[8]      = lookup_ready;
            rd_data[PW-1:0] = lookup_preg;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= ST_IDLE;
            last_b_id <= '0;
        end else begin
            state <= req ? ST_ACK : ST_IDLE;
            if (checkpoint_en) begin
                last_b_id <= new_b_id;
            end
        end
    end

    // read data is captured as ack rises
    always_ff @(posedge clock) begin
        if (req) begin
            dat_r <= we ? '0 : rd_data;
        end
    end

    a_ack_single: assert property (
        @(posedge clock) disable iff (reset)
        ack |=> !ack
    ) else $error("ack held for more than one cycle");

endmodule

// ==== rename_pkg.sv ====
package rename_pkg;

    // wishbone classic bus widths
    typedef logic [7:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;

    // what a resolve command does to the branch stack
    typedef enum logic [1:0] {
        BR_NONE,
        BR_CLEAR,
        BR_SQUASH
    } br_task_t;

    // write command addresses
    localparam wb_adr_t ADR_RENAME    = 8'h00;
    localparam wb_adr_t ADR_BRANCH    = 8'h01;
    localparam wb_adr_t ADR_RESOLVE   = 8'h02;
    localparam wb_adr_t ADR_BROADCAST = 8'h03;
    localparam wb_adr_t ADR_RELEASE   = 8'h04;

    // read addresses, map entries sit at base plus architectural index
    localparam wb_adr_t ADR_MAP_BASE  = 8'h40;
    localparam wb_adr_t ADR_STATUS    = 8'h80;

endpackage

// ==== rename_top.sv ====
`timescale 1ns/1ps

module rename_top #(
    parameter int ARCH_REGS = 32,
    parameter int PHYS_REGS = 64,
    parameter int DEPTH     = 4
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  rename_pkg::wb_adr_t adr,
    input  rename_pkg::wb_dat_t dat_w,
    output rename_pkg::wb_dat_t dat_r,
    output logic                ack
);

    localparam int AW   = $clog2(ARCH_REGS);
    localparam int PW   = $clog2(PHYS_REGS);
    localparam int PTRW = $clog2(PHYS_REGS - ARCH_REGS) + 1;
    localparam int MW   = ARCH_REGS * (PW + 1);

    logic                 rename_en;
    logic [AW-1:0]        rename_arch;
    logic                 release_en;
    logic [PW-1:0]        release_preg;
    logic                 broadcast_en;
    logic [PW-1:0]        broadcast_preg;
    logic                 checkpoint_en;
    rename_pkg::br_task_t br_task;
    logic [DEPTH-1:0]     rem_b_id;
    logic [AW-1:0]        lookup_arch;
    logic [PW-1:0]        lookup_preg;
    logic                 lookup_ready;
    logic [MW-1:0]        map_flat;
    logic [PW-1:0]        head_preg;
    logic [PTRW-1:0]      head_ptr;
    logic [PTRW-1:0]      count;
    logic                 empty;
    logic                 full;
    logic [DEPTH-1:0]     new_b_id;
    logic                 restore_en;
    logic [MW-1:0]        restore_map;
    logic [PTRW-1:0]      restore_head;

    rename_ctrl #(
        .ARCH_REGS(ARCH_REGS),
        .PHYS_REGS(PHYS_REGS),
        .DEPTH(DEPTH)
    ) rename_ctrl_i (.*);

    // the new mapping comes from the free-list head
    map_table #(
        .ARCH_REGS(ARCH_REGS),
        .PHYS_REGS(PHYS_REGS)
    ) map_table_i (
        .rename_preg(head_preg),
        .*
    );

    free_list #(
        .ARCH_REGS(ARCH_REGS),
        .PHYS_REGS(PHYS_REGS)
    ) free_list_i (
        .alloc_en(rename_en),
        .*
    );

    br_stack #(
        .ARCH_REGS(ARCH_REGS),
        .PHYS_REGS(PHYS_REGS),
        .DEPTH(DEPTH)
    ) br_stack_i (
        .fl_head(head_ptr),
        .*
    );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_rename_top
out=$(./obj_dir/Vtb_rename_top)
echo "$out"
echo "$out" | grep -qx "ALL TESTS PASSED"

// ==== tb.f ====
rename_pkg.sv
map_table.sv
free_list.sv
br_stack.sv
rename_ctrl.sv
rename_top.sv
tb_rename_top.sv

// ==== tb_rename_top.sv ====
`timescale 1ns/1ps

module tb_rename_top;

    localparam int ACK_TIMEOUT = 20;

    logic                clock;
    logic                reset;
    logic                cyc;
    logic                stb;
    logic                we;
    rename_pkg::wb_adr_t adr;
    rename_pkg::wb_dat_t dat_w;
    rename_pkg::wb_dat_t dat_r;
    logic                ack;

    // stimulus table, one entry per bus cycle
    string               names [$];
    logic                we_q  [$];
    rename_pkg::wb_adr_t adr_q [$];
    rename_pkg::wb_dat_t dat_q [$];
    rename_pkg::wb_dat_t exp_q [$];

    int   errors;
    int   checks;
    logic bus_dead;

    rename_top #(
        .ARCH_REGS(32),
        .PHYS_REGS(64),
        .DEPTH(4)
    ) rename_top_i (
        .clock(clock),
        .reset(reset),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .dat_w(dat_w),
        .dat_r(dat_r),
        .ack(ack)
    );

    always #4 clock = ~clock;

    // map read layout is {ready at bit 8, preg in 5:0}
    function automatic rename_pkg::wb_dat_t map_word(input logic ready, input logic [5:0] preg);
        rename_pkg::wb_dat_t w;
        w      = '0;
        w[8]   = ready;
        w[5:0] = preg;
        return w;
    endfunction

    function automatic rename_pkg::wb_dat_t status_word(input logic full, input logic empty,
                                                        input logic [3:0] b_id,
                                                        input logic [7:0] cnt);
        rename_pkg::wb_dat_t w;
        w        = '0;
        w[31]    = full;
        w[30]    = empty;
        w[19:16] = b_id;
        w[7:0]   = cnt;
        return w;
    endfunction

    function automatic rename_pkg::wb_adr_t map_adr(input int arch);
        return rename_pkg::ADR_MAP_BASE + 8'(arch);
    endfunction

    task automatic add_row(input string name, input logic wr, input rename_pkg::wb_adr_t a,
                           input rename_pkg::wb_dat_t d, input rename_pkg::wb_dat_t e);
        names.push_back(name);
        we_q.push_back(wr);
        adr_q.push_back(a);
        dat_q.push_back(d);
        exp_q.push_back(e);
    endtask

    task automatic add_write(input string name, input rename_pkg::wb_adr_t a,
                             input rename_pkg::wb_dat_t d);
        add_row(name, 1'b1, a, d, '0);
    endtask

    task automatic add_read(input string name, input rename_pkg::wb_adr_t a,
                            input rename_pkg::wb_dat_t e);
        add_row(name, 1'b0, a, '0, e);
    endtask

    task automatic build_table();
        // identity map after reset, 32 free registers
        add_read("reset map r0", map_adr(0), map_word(1'b1, 6'd0));
        add_read("reset map r7", map_adr(7), map_word(1'b1, 6'd7));
        add_read("reset map r31", map_adr(31), map_word(1'b1, 6'd31));
        add_read("reset status", rename_pkg::ADR_STATUS, status_word(1'b0, 1'b0, 4'h0, 8'd32));

        add_write("rename r3", rename_pkg::ADR_RENAME, 32'd3);
        add_write("rename r5", rename_pkg::ADR_RENAME, 32'd5);
        add_read("r3 renamed", map_adr(3), map_word(1'b0, 6'd32));
        add_read("r5 renamed", map_adr(5), map_word(1'b0, 6'd33));
        add_read("count after renames", rename_pkg::ADR_STATUS,
                 status_word(1'b0, 1'b0, 4'h0, 8'd30));
        add_write("broadcast p33", rename_pkg::ADR_BROADCAST, 32'd33);
        add_read("r5 ready", map_adr(5), map_word(1'b1, 6'd33));
        add_read("r3 still busy", map_adr(3), map_word(1'b0, 6'd32));

        // single branch, speculative rename, squash
        add_write("branch a", rename_pkg::ADR_BRANCH, 32'd0);
        add_write("rename r3 under branch", rename_pkg::ADR_RENAME, 32'd3);
        add_read("r3 speculative", map_adr(3), map_word(1'b0, 6'd34));
        add_write("squash branch a", rename_pkg::ADR_RESOLVE, 32'h101);
        add_read("r3 restored", map_adr(3), map_word(1'b0, 6'd32));
        add_read("r5 kept", map_adr(5), map_word(1'b1, 6'd33));
        add_read("status after squash", rename_pkg::ADR_STATUS,
                 status_word(1'b0, 1'b0, 4'h1, 8'd30));
        add_write("rename r6", rename_pkg::ADR_RENAME, 32'd6);
        add_read("r6 reuses p34", map_adr(6), map_word(1'b0, 6'd34));

        // outer branch id 1 then inner branch id 2
        add_write("branch outer", rename_pkg::ADR_BRANCH, 32'd0);
        add_write("rename r10", rename_pkg::ADR_RENAME, 32'd10);
        add_write("branch inner", rename_pkg::ADR_BRANCH, 32'd0);
        add_write("rename r10 again", rename_pkg::ADR_RENAME, 32'd10);
        add_write("rename r11", rename_pkg::ADR_RENAME, 32'd11);
        add_read("r10 under inner", map_adr(10), map_word(1'b0, 6'd36));
        add_write("clear outer", rename_pkg::ADR_RESOLVE, 32'h001);
        add_write("squash inner", rename_pkg::ADR_RESOLVE, 32'h102);
        add_read("r10 restored", map_adr(10), map_word(1'b0, 6'd35));
        add_read("r11 restored", map_adr(11), map_word(1'b1, 6'd11));
        add_read("status after nested", rename_pkg::ADR_STATUS,
                 status_word(1'b0, 1'b0, 4'h2, 8'd28));
        for (int i = 0; i < 4; i++) begin
            add_write("fill stack", rename_pkg::ADR_BRANCH, 32'd0);
        end
        add_read("stack full", rename_pkg::ADR_STATUS, status_word(1'b1, 1'b0, 4'h8, 8'd28));
        add_write("branch when full", rename_pkg::ADR_BRANCH, 32'd0);
        add_read("full branch ignored", rename_pkg::ADR_STATUS,
                 status_word(1'b1, 1'b0, 4'h8, 8'd28));
        // every mask holds the oldest id, so this empties the stack
        add_write("squash oldest", rename_pkg::ADR_RESOLVE, 32'h101);
        // an empty stack hands out ids 1 and 2 again
        add_write("branch after flush", rename_pkg::ADR_BRANCH, 32'd0);
        add_write("second branch after flush", rename_pkg::ADR_BRANCH, 32'd0);
        add_read("stack emptied", rename_pkg::ADR_STATUS, status_word(1'b0, 1'b0, 4'h2, 8'd28));
        add_write("squash after flush", rename_pkg::ADR_RESOLVE, 32'h101);
        add_read("r10 after flush", map_adr(10), map_word(1'b0, 6'd35));

        // result arrives after the checkpoint was taken
        add_write("rename r12", rename_pkg::ADR_RENAME, 32'd12);
        add_write("branch c", rename_pkg::ADR_BRANCH, 32'd0);
        add_write("broadcast p36", rename_pkg::ADR_BROADCAST, 32'd36);
        add_write("rename r13", rename_pkg::ADR_RENAME, 32'd13);
        add_read("r13 speculative", map_adr(13), map_word(1'b0, 6'd37));
        add_write("squash branch c", rename_pkg::ADR_RESOLVE, 32'h101);
        add_read("r12 ready after squash", map_adr(12), map_word(1'b1, 6'd36));
        add_read("r13 restored", map_adr(13), map_word(1'b1, 6'd13));
        add_read("status after c", rename_pkg::ADR_STATUS, status_word(1'b0, 1'b0, 4'h1, 8'd27));

        // drain the remaining 27 free registers into r20
        for (int i = 0; i < 27; i++) begin
            add_write("drain", rename_pkg::ADR_RENAME, 32'd20);
        end
        add_read("r20 last preg", map_adr(20), map_word(1'b0, 6'd63));
        add_read("free list empty", rename_pkg::ADR_STATUS,
                 status_word(1'b0, 1'b1, 4'h1, 8'd0));
        add_write("rename when empty", rename_pkg::ADR_RENAME, 32'd21);
        add_read("r21 unchanged", map_adr(21), map_word(1'b1, 6'd21));
        add_read("empty status kept", rename_pkg::ADR_STATUS,
                 status_word(1'b0, 1'b1, 4'h1, 8'd0));
        add_write("release p7", rename_pkg::ADR_RELEASE, 32'd7);
        add_read("one free", rename_pkg::ADR_STATUS, status_word(1'b0, 1'b0, 4'h1, 8'd1));
        add_write("rename r21 from p7", rename_pkg::ADR_RENAME, 32'd21);
        add_read("r21 gets p7", map_adr(21), map_word(1'b0, 6'd7));
        add_read("empty again", rename_pkg::ADR_STATUS, status_word(1'b0, 1'b1, 4'h1, 8'd0));
    endtask

    // one bus cycle: drive, wait for ack, check read data, drop the strobe
    task automatic apply_row(input int idx);
        logic got;
        got = 1'b0;
        @(posedge clock);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= we_q[idx];
        adr   <= adr_q[idx];
        dat_w <= dat_q[idx];
        for (int t = 0; t < ACK_TIMEOUT && !got; t++) begin
            @(negedge clock);
            got = ack;
        end
        if (!got) begin
            $display("no acknowledge from bus in %s", names[idx]);
            errors   = errors + 1;
            bus_dead = 1'b1;
        end else if (!we_q[idx]) begin
            checks = checks + 1;
            assert (dat_r == exp_q[idx]) else begin
                errors = errors + 1;
                $display("Fail %s: expected %h, actual %h", names[idx], exp_q[idx], dat_r);
            end
        end
        @(posedge clock);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    initial begin
        clock    = 1'b0;
        reset    = 1'b1;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        dat_w    = '0;
        errors   = 0;
        checks   = 0;
        bus_dead = 1'b0;
        build_table();
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < names.size() && !bus_dead; i++) begin
            apply_row(i);
        end
        $display("read checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
